/* xcvr_phy_settings.svh */
//////////////////////////////////////////////////////////////////////
// sizes, register map and sequencer delays for the PHY management side
// include before any module or package that needs them
//////////////////////////////////////////////////////////////////////
`ifndef XCVR_PHY_SETTINGS_SVH
`define XCVR_PHY_SETTINGS_SVH

`define XCVR_LANES          4
`define XCVR_DATA_W         32
`define XCVR_ADDR_W         8

// register map, byte addresses on the management bus
`define XCVR_ADDR_STATUS    8'h01
`define XCVR_ADDR_RESET_CMD 8'h02
`define XCVR_ADDR_TX_DIGRST 8'h03
`define XCVR_ADDR_RX_ANARST 8'h04
`define XCVR_ADDR_RX_DIGRST 8'h05
`define XCVR_ADDR_LOOPBACK  8'h06
`define XCVR_ADDR_LOCK_MODE 8'h07

`define XCVR_PLL_PD_CYCLES  8   // pll power-down hold
`define XCVR_LTD_CYCLES     6   // cdr settle, all lanes locked
`define XCVR_TIMER_W        8

`endif

/* xcvr_phy_pkg.sv */
//////////////////////////////////////////////////////////////////////
// shared types: sequencer states, register addresses, status/control
//////////////////////////////////////////////////////////////////////
`default_nettype none

`include "xcvr_phy_settings.svh"

package xcvr_phy_pkg;

  typedef enum logic [2:0] {
    ST_PLL_PD,      // everything held in reset
    ST_WAIT_PLL,    // pll up, waiting for lock and tx cal
    ST_RX_ANARST,   // tx running, rx analog still in reset
    ST_WAIT_CDR,    // cdr settle window
    ST_READY
  } reset_state_e;

  typedef enum logic [`XCVR_ADDR_W-1:0] {
    CSR_STATUS    = `XCVR_ADDR_STATUS,
    CSR_RESET_CMD = `XCVR_ADDR_RESET_CMD,
    CSR_TX_DIGRST = `XCVR_ADDR_TX_DIGRST,
    CSR_RX_ANARST = `XCVR_ADDR_RX_ANARST,
    CSR_RX_DIGRST = `XCVR_ADDR_RX_DIGRST,
    CSR_LOOPBACK  = `XCVR_ADDR_LOOPBACK,
    CSR_LOCK_MODE = `XCVR_ADDR_LOCK_MODE
  } csr_addr_e;

  typedef struct packed {
    logic                   pll_locked;
    logic                   tx_cal_busy;
    logic                   rx_cal_busy;
    logic [`XCVR_LANES-1:0] rx_is_lockedtodata;
  } xcvr_status_t;

  typedef struct packed {
    logic                   pll_powerdown;
    logic [`XCVR_LANES-1:0] tx_analogreset;
    logic [`XCVR_LANES-1:0] tx_digitalreset;
    logic [`XCVR_LANES-1:0] rx_analogreset;
    logic [`XCVR_LANES-1:0] rx_digitalreset;
  } lane_reset_t;

  typedef struct packed {
    logic [`XCVR_LANES-1:0] tx_digrst;
    logic [`XCVR_LANES-1:0] rx_anarst;
    logic [`XCVR_LANES-1:0] rx_digrst;
    logic                   reset_all;    // one-cycle pulse
    logic                   reset_rx;     // one-cycle pulse
    logic                   manual_lock;
  } csr_ctrl_t;

  typedef struct packed {
    logic [`XCVR_LANES-1:0] seriallpbken;
    logic [`XCVR_LANES-1:0] set_locktoref;
    logic [`XCVR_LANES-1:0] set_locktodata;
  } xcvr_ctrl_t;

endpackage

`default_nettype wire

/* xcvr_reset_timer.sv */
//////////////////////////////////////////////////////////////////////
// down-counter for the reset sequencer's power-down and settle windows
//////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

`include "xcvr_phy_settings.svh"

module xcvr_reset_timer (
  input  wire logic                     mgmt_clk,
  input  wire logic                     embedded_reset,
  input  wire logic                     timer_load,
  input  wire logic [`XCVR_TIMER_W-1:0] timer_value,  // must be 1 or more
  output logic                          timer_done
);

  logic [`XCVR_TIMER_W-1:0] count;

  // load value-1 so done shows exactly timer_value cycles after the load
  always_ff @(posedge mgmt_clk) begin
    if (embedded_reset) begin
      count <= '0;                 // idle and done
    end else if (timer_load) begin
      count <= timer_value - 1'b1;
    end else if (count != '0) begin
      count <= count - 1'b1;
    end
  end

  // level, held until the next load
  assign timer_done = (count == '0);

endmodule

`default_nettype wire

/* xcvr_reset_seq.sv */
//////////////////////////////////////////////////////////////////////
// embedded reset sequencer: pll power-down, tx release, rx release
// lane resets are the per-state resets ORed with the csr overrides
//////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

`include "xcvr_phy_settings.svh"

module xcvr_reset_seq
  import xcvr_phy_pkg::*;
(
  input  wire logic                     mgmt_clk,
  input  wire logic                     embedded_reset,
  input  wire xcvr_status_t             xcvr_status,
  input  wire csr_ctrl_t                csr_ctrl,
  output lane_reset_t                   lane_reset,
  output logic                          tx_ready,
  output logic                          rx_ready,
  output logic                          timer_load,
  output logic [`XCVR_TIMER_W-1:0]      timer_value,
  input  wire logic                     timer_done
);

  reset_state_e state;
  reset_state_e state_nxt;
  logic         load_nxt;
  logic         all_locked;
  logic         timed_out;
  logic         pll_pd_q;
  logic         rx_ana_q;

  assign all_locked = &xcvr_status.rx_is_lockedtodata;
  assign timed_out  = timer_done && !timer_load;   // ignore stale done in load cycle

  assign timer_value = (state == ST_WAIT_CDR) ? `XCVR_TIMER_W'(`XCVR_LTD_CYCLES)
                                              : `XCVR_TIMER_W'(`XCVR_PLL_PD_CYCLES);

  //////////////////////////////////////////////////////////////////////
  // next state
  //////////////////////////////////////////////////////////////////////
  always_comb begin
    state_nxt = state;
    case (state)
      ST_PLL_PD:    if (timed_out) state_nxt = ST_WAIT_PLL;
      ST_WAIT_PLL:  if (xcvr_status.pll_locked && !xcvr_status.tx_cal_busy) begin
        state_nxt = ST_RX_ANARST;
      end
      ST_RX_ANARST: if (!xcvr_status.rx_cal_busy) state_nxt = ST_WAIT_CDR;
      ST_WAIT_CDR:  if (timed_out && (all_locked || csr_ctrl.manual_lock)) begin
        state_nxt = ST_READY;
      end
      ST_READY:     if (!all_locked && !csr_ctrl.manual_lock) state_nxt = ST_WAIT_CDR;
      default:      state_nxt = ST_PLL_PD;
    endcase

    // commands; reset rx only once tx is up
    if (csr_ctrl.reset_rx && (state != ST_PLL_PD) && (state != ST_WAIT_PLL)) begin
      state_nxt = ST_RX_ANARST;
    end
    if (csr_ctrl.reset_all) begin
      state_nxt = ST_PLL_PD;
    end
  end

  // arm timer on entry to a timed state, rearm while any lane is unlocked
  assign load_nxt = csr_ctrl.reset_all ||
                    ((state_nxt == ST_WAIT_CDR) &&
                     ((state != ST_WAIT_CDR) || (!all_locked && !csr_ctrl.manual_lock)));

  //////////////////////////////////////////////////////////////////////
  // state and registered per-state resets
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge mgmt_clk) begin
    if (embedded_reset) begin
      state      <= ST_PLL_PD;
      timer_load <= 1'b1;        // power-down window starts as reset drops
      pll_pd_q   <= 1'b1;
      rx_ana_q   <= 1'b1;
      tx_ready   <= 1'b0;
      rx_ready   <= 1'b0;
    end else begin
      state      <= state_nxt;
      timer_load <= load_nxt;
      pll_pd_q   <= (state_nxt == ST_PLL_PD);
      rx_ana_q   <= state_nxt inside {ST_PLL_PD, ST_WAIT_PLL, ST_RX_ANARST};
      tx_ready   <= state_nxt inside {ST_RX_ANARST, ST_WAIT_CDR, ST_READY};
      rx_ready   <= (state_nxt == ST_READY);
    end
  end

  // final lane resets
  assign lane_reset.pll_powerdown   = pll_pd_q;
  assign lane_reset.tx_analogreset  = {`XCVR_LANES{pll_pd_q}};  // tracks pll power-down
  assign lane_reset.tx_digitalreset = {`XCVR_LANES{!tx_ready}} | csr_ctrl.tx_digrst;
  assign lane_reset.rx_analogreset  = {`XCVR_LANES{rx_ana_q}} | csr_ctrl.rx_anarst;
  assign lane_reset.rx_digitalreset = {`XCVR_LANES{!rx_ready}} | csr_ctrl.rx_digrst;

endmodule

`default_nettype wire

/* xcvr_mgmt_csr.sv */
//////////////////////////////////////////////////////////////////////
// management register file: lane overrides, commands, loopback, lock
// writes take effect next cycle, reads take two cycles via waitrequest
//////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

`include "xcvr_phy_settings.svh"

module xcvr_mgmt_csr
  import xcvr_phy_pkg::*;
(
  input  wire logic                    mgmt_clk,
  input  wire logic                    embedded_reset,
  input  wire logic [`XCVR_ADDR_W-1:0] mgmt_address,
  input  wire logic                    mgmt_read,
  input  wire logic                    mgmt_write,
  input  wire logic [`XCVR_DATA_W-1:0] mgmt_writedata,
  input  wire xcvr_status_t            xcvr_status,
  input  wire logic                    tx_ready,
  input  wire logic                    rx_ready,
  output logic [`XCVR_DATA_W-1:0]      mgmt_readdata,
  output logic                         mgmt_waitrequest,
  output csr_ctrl_t                    csr_ctrl,
  output xcvr_ctrl_t                   xcvr_ctrl
);

  logic [`XCVR_LANES-1:0]  tx_digrst_q;
  logic [`XCVR_LANES-1:0]  rx_anarst_q;
  logic [`XCVR_LANES-1:0]  rx_digrst_q;
  logic [`XCVR_LANES-1:0]  loopback_q;
  logic [1:0]              lock_mode_q;   // [0] lock to ref, [1] lock to data
  logic                    reset_all_q;
  logic                    reset_rx_q;
  logic                    rd_ack_q;
  logic                    wr_cmd;
  logic [`XCVR_DATA_W-1:0] rd_mux;
  logic [`XCVR_DATA_W-1:0] readdata_q;

  assign wr_cmd = mgmt_write && (mgmt_address == CSR_RESET_CMD);

  //////////////////////////////////////////////////////////////////////
  // write side
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge mgmt_clk) begin
    if (embedded_reset) begin
      tx_digrst_q <= '0;
      rx_anarst_q <= '0;
      rx_digrst_q <= '0;
      loopback_q  <= '0;
      lock_mode_q <= '0;
      reset_all_q <= 1'b0;
      reset_rx_q  <= 1'b0;
      rd_ack_q    <= 1'b0;
    end else begin
      reset_all_q <= wr_cmd && mgmt_writedata[0];   // single-cycle pulses
      reset_rx_q  <= wr_cmd && mgmt_writedata[1];
      rd_ack_q    <= mgmt_read && !rd_ack_q;
      if (mgmt_write) begin
        case (mgmt_address)
          CSR_TX_DIGRST: tx_digrst_q <= mgmt_writedata[`XCVR_LANES-1:0];
          CSR_RX_ANARST: rx_anarst_q <= mgmt_writedata[`XCVR_LANES-1:0];
          CSR_RX_DIGRST: rx_digrst_q <= mgmt_writedata[`XCVR_LANES-1:0];
          CSR_LOOPBACK:  loopback_q  <= mgmt_writedata[`XCVR_LANES-1:0];
          CSR_LOCK_MODE: lock_mode_q <= mgmt_writedata[1:0];
          default: ;
        endcase
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // read side
  //////////////////////////////////////////////////////////////////////
  always_comb begin
    case (mgmt_address)
      CSR_STATUS:    rd_mux = `XCVR_DATA_W'({xcvr_status.rx_cal_busy,
                                             xcvr_status.tx_cal_busy,
                                             rx_ready,
                                             tx_ready,
                                             xcvr_status.rx_is_lockedtodata,
                                             xcvr_status.pll_locked});
      CSR_RESET_CMD: rd_mux = '0;
      CSR_TX_DIGRST: rd_mux = `XCVR_DATA_W'(tx_digrst_q);
      CSR_RX_ANARST: rd_mux = `XCVR_DATA_W'(rx_anarst_q);
      CSR_RX_DIGRST: rd_mux = `XCVR_DATA_W'(rx_digrst_q);
      CSR_LOOPBACK:  rd_mux = `XCVR_DATA_W'(loopback_q);
      CSR_LOCK_MODE: rd_mux = `XCVR_DATA_W'(lock_mode_q);
      default:       rd_mux = '1;   // undecoded
    endcase
  end

  // capture in the wait cycle, present in the second
  always_ff @(posedge mgmt_clk) begin
    if (mgmt_read && !rd_ack_q) begin
      readdata_q <= rd_mux;
    end
  end

  assign mgmt_readdata    = readdata_q;
  assign mgmt_waitrequest = mgmt_read && !rd_ack_q;

  // to sequencer
  assign csr_ctrl.tx_digrst   = tx_digrst_q;
  assign csr_ctrl.rx_anarst   = rx_anarst_q;
  assign csr_ctrl.rx_digrst   = rx_digrst_q;
  assign csr_ctrl.reset_all   = reset_all_q;
  assign csr_ctrl.reset_rx    = reset_rx_q;
  assign csr_ctrl.manual_lock = |lock_mode_q;   // any forced lock skips cdr wait

  // to transceiver
  assign xcvr_ctrl.seriallpbken   = loopback_q;
  assign xcvr_ctrl.set_locktoref  = {`XCVR_LANES{lock_mode_q[0]}};
  assign xcvr_ctrl.set_locktodata = {`XCVR_LANES{lock_mode_q[1]}};

endmodule

`default_nettype wire

/* xcvr_phy_ctrl.sv */
//////////////////////////////////////////////////////////////////////
// PHY management top: csr block, reset sequencer and its timer
//////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

`include "xcvr_phy_settings.svh"

module xcvr_phy_ctrl
  import xcvr_phy_pkg::*;
(
  input  wire logic                    mgmt_clk,
  input  wire logic                    embedded_reset,
  input  wire logic [`XCVR_ADDR_W-1:0] mgmt_address,
  input  wire logic                    mgmt_read,
  output logic [`XCVR_DATA_W-1:0]      mgmt_readdata,
  input  wire logic                    mgmt_write,
  input  wire logic [`XCVR_DATA_W-1:0] mgmt_writedata,
  output logic                         mgmt_waitrequest,
  input  wire xcvr_status_t            xcvr_status,
  output lane_reset_t                  lane_reset,
  output xcvr_ctrl_t                   xcvr_ctrl,
  output logic                         tx_ready,
  output logic                         rx_ready
);

  csr_ctrl_t                csr_ctrl;      // overrides and commands
  logic                     timer_load;
  logic [`XCVR_TIMER_W-1:0] timer_value;
  logic                     timer_done;

  xcvr_mgmt_csr csr_i (
    .mgmt_clk         (mgmt_clk),
    .embedded_reset   (embedded_reset),
    .mgmt_address     (mgmt_address),
    .mgmt_read        (mgmt_read),
    .mgmt_write       (mgmt_write),
    .mgmt_writedata   (mgmt_writedata),
    .xcvr_status      (xcvr_status),
    .tx_ready         (tx_ready),
    .rx_ready         (rx_ready),
    .mgmt_readdata    (mgmt_readdata),
    .mgmt_waitrequest (mgmt_waitrequest),
    .csr_ctrl         (csr_ctrl),
    .xcvr_ctrl        (xcvr_ctrl)
  );

  xcvr_reset_seq reset_seq_i (
    .mgmt_clk       (mgmt_clk),
    .embedded_reset (embedded_reset),
    .xcvr_status    (xcvr_status),
    .csr_ctrl       (csr_ctrl),
    .lane_reset     (lane_reset),
    .tx_ready       (tx_ready),
    .rx_ready       (rx_ready),
    .timer_load     (timer_load),
    .timer_value    (timer_value),
    .timer_done     (timer_done)
  );

  xcvr_reset_timer reset_timer_i (
    .mgmt_clk       (mgmt_clk),
    .embedded_reset (embedded_reset),
    .timer_load     (timer_load),
    .timer_value    (timer_value),
    .timer_done     (timer_done)
  );

endmodule

`default_nettype wire

/* xcvr_phy_ctrl_sva.sv */
//////////////////////////////////////////////////////////////////////
// sequencing and read handshake checks, bound to the PHY control top
//////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

`include "xcvr_phy_settings.svh"

module xcvr_phy_ctrl_sva
  import xcvr_phy_pkg::*;
(
  input  wire logic         mgmt_clk,
  input  wire logic         embedded_reset,
  input  wire logic         mgmt_read,
  input  wire logic         mgmt_waitrequest,
  input  wire xcvr_status_t xcvr_status,
  input  wire csr_ctrl_t    csr_ctrl,
  input  wire lane_reset_t  lane_reset,
  input  wire logic         tx_ready,
  input  wire logic         rx_ready
);

  logic [`XCVR_TIMER_W-1:0] pd_cnt;     // cycles since reset or reset all
  logic [`XCVR_TIMER_W-1:0] lock_cnt;   // consecutive cycles with every lane locked
  logic                     all_locked;

  assign all_locked = &xcvr_status.rx_is_lockedtodata;

  always_ff @(posedge mgmt_clk) begin
    if (embedded_reset || csr_ctrl.reset_all) begin
      pd_cnt <= '0;
    end else if (pd_cnt != '1) begin
      pd_cnt <= pd_cnt + 1'b1;   // saturates
    end
  end

  always_ff @(posedge mgmt_clk) begin
    if (embedded_reset || !all_locked) begin
      lock_cnt <= '0;
    end else if (lock_cnt != '1) begin
      lock_cnt <= lock_cnt + 1'b1;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // reset sequencing
  //////////////////////////////////////////////////////////////////////
  a_pll_pd_hold: assert property (@(posedge mgmt_clk) disable iff (embedded_reset)
    (pd_cnt < `XCVR_PLL_PD_CYCLES) |-> lane_reset.pll_powerdown)
    else $error("pll_powerdown released before the power-down window ended");

  a_tx_ready_cond: assert property (@(posedge mgmt_clk) disable iff (embedded_reset)
    $rose(tx_ready) |-> $past(xcvr_status.pll_locked && !xcvr_status.tx_cal_busy))
    else $error("tx_ready rose without pll lock and finished tx calibration");

  a_tx_digrst: assert property (@(posedge mgmt_clk) disable iff (embedded_reset)
    (csr_ctrl.tx_digrst == '0) |-> (lane_reset.tx_digitalreset == {`XCVR_LANES{!tx_ready}}))
    else $error("tx_digitalreset does not follow tx_ready");

  a_rx_digrst: assert property (@(posedge mgmt_clk) disable iff (embedded_reset)
    (csr_ctrl.rx_digrst == '0) |-> (lane_reset.rx_digitalreset == {`XCVR_LANES{!rx_ready}}))
    else $error("rx_digitalreset does not follow rx_ready");

  a_cdr_settle: assert property (@(posedge mgmt_clk) disable iff (embedded_reset)
    ($rose(rx_ready) && !csr_ctrl.manual_lock) |-> (lock_cnt >= `XCVR_LTD_CYCLES))
    else $error("rx_ready rose before the lanes settled");

  a_lock_loss: assert property (@(posedge mgmt_clk) disable iff (embedded_reset)
    (rx_ready && !all_locked && !csr_ctrl.manual_lock) |=> !rx_ready)
    else $error("rx_ready held after a lane lost lock");

  a_rx_cmd_keeps_tx: assert property (@(posedge mgmt_clk) disable iff (embedded_reset)
    (csr_ctrl.reset_rx && !csr_ctrl.reset_all && tx_ready) |=> tx_ready)
    else $error("reset rx command dropped tx_ready");

  //////////////////////////////////////////////////////////////////////
  // read wait request
  //////////////////////////////////////////////////////////////////////
  a_wait_first: assert property (@(posedge mgmt_clk) disable iff (embedded_reset)
    $rose(mgmt_read) |-> mgmt_waitrequest)
    else $error("waitrequest low in the first read cycle");

  a_wait_once: assert property (@(posedge mgmt_clk) disable iff (embedded_reset)
    mgmt_waitrequest |=> !mgmt_waitrequest)
    else $error("waitrequest high for more than one cycle");

  a_wait_idle: assert property (@(posedge mgmt_clk) disable iff (embedded_reset)
    !mgmt_read |-> !mgmt_waitrequest)
    else $error("waitrequest high without a read");

endmodule

`default_nettype wire

/* xcvr_phy_ctrl_tb.sv */
//////////////////////////////////////////////////////////////////////
// testbench: transceiver status model, csr traffic, reset sequencing
//////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

`include "xcvr_phy_settings.svh"

module xcvr_phy_ctrl_tb
  import xcvr_phy_pkg::*;
();

  localparam int          WAIT_LIMIT = 400;
  localparam logic [31:0] LANE_MASK  = (32'd1 << `XCVR_LANES) - 32'd1;

  logic                    mgmt_clk;
  logic                    embedded_reset;
  logic [`XCVR_ADDR_W-1:0] mgmt_address;
  logic                    mgmt_read;
  logic                    mgmt_write;
  logic [`XCVR_DATA_W-1:0] mgmt_writedata;
  logic [`XCVR_DATA_W-1:0] mgmt_readdata;
  logic                    mgmt_waitrequest;
  xcvr_status_t            xcvr_status;
  lane_reset_t             lane_reset;
  xcvr_ctrl_t              xcvr_ctrl;
  logic                    tx_ready;
  logic                    rx_ready;
  logic [31:0]             rd;
  logic [31:0]             exp;
  logic [31:0]             tx_val;
  logic [31:0]             rxa_val;
  logic [31:0]             rxd_val;
  logic [31:0]             lpb_val;
  int                      lane;

  always #20 mgmt_clk = ~mgmt_clk;

  xcvr_phy_ctrl dut_i (
    .mgmt_clk         (mgmt_clk),
    .embedded_reset   (embedded_reset),
    .mgmt_address     (mgmt_address),
    .mgmt_read        (mgmt_read),
    .mgmt_readdata    (mgmt_readdata),
    .mgmt_write       (mgmt_write),
    .mgmt_writedata   (mgmt_writedata),
    .mgmt_waitrequest (mgmt_waitrequest),
    .xcvr_status      (xcvr_status),
    .lane_reset       (lane_reset),
    .xcvr_ctrl        (xcvr_ctrl),
    .tx_ready         (tx_ready),
    .rx_ready         (rx_ready)
  );

  bind xcvr_phy_ctrl xcvr_phy_ctrl_sva sva_i (
    .mgmt_clk         (mgmt_clk),
    .embedded_reset   (embedded_reset),
    .mgmt_read        (mgmt_read),
    .mgmt_waitrequest (mgmt_waitrequest),
    .xcvr_status      (xcvr_status),
    .csr_ctrl         (csr_ctrl),
    .lane_reset       (lane_reset),
    .tx_ready         (tx_ready),
    .rx_ready         (rx_ready)
  );

  //////////////////////////////////////////////////////////////////////
  // helpers
  //////////////////////////////////////////////////////////////////////
  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Simulation failed");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] want);
    assert (got === want) else begin
      abort_run($sformatf("CHECK FAILED at %0t: %s is 0x%0h, expected 0x%0h",
                          $time, name, got, want));
    end
  endtask

  task automatic next_cycle();
    @(posedge mgmt_clk);
    #2;   // drive just after the edge
  endtask

  task automatic wait_ready(input logic tx_lvl, input logic rx_lvl, input string what);
    int n;
    n = 0;
    while (!((tx_ready === tx_lvl) && (rx_ready === rx_lvl))) begin
      next_cycle();
      n++;
      if (n > WAIT_LIMIT) abort_run($sformatf("timed out waiting for %s", what));
    end
  endtask

  task automatic csr_write(input logic [`XCVR_ADDR_W-1:0] addr, input logic [31:0] data);
    mgmt_address   = addr;
    mgmt_writedata = data;
    mgmt_write     = 1'b1;
    next_cycle();
    mgmt_write     = 1'b0;
  endtask

  task automatic csr_read(input logic [`XCVR_ADDR_W-1:0] addr, output logic [31:0] data);
    int n;
    n            = 0;
    mgmt_address = addr;
    mgmt_read    = 1'b1;
    next_cycle();
    while (mgmt_waitrequest) begin   // hold read until wait drops
      next_cycle();
      n++;
      if (n > WAIT_LIMIT) abort_run("read never completed, waitrequest stuck high");
    end
    data      = mgmt_readdata;
    mgmt_read = 1'b0;
    next_cycle();
  endtask

  task automatic write_readback(input logic [`XCVR_ADDR_W-1:0] addr, input string name,
                                output logic [31:0] val);
    logic [31:0] got;
    val = $urandom();
    csr_write(addr, val);
    csr_read(addr, got);
    val = val & LANE_MASK;   // only lane bits are stored
    check_value(name, got, val);
  endtask

  // pll lock, tx cal, rx cal, then staggered lane lock
  task automatic bring_up();
    int i;
    check_value("pll_powerdown", 32'(lane_reset.pll_powerdown), 32'd1);
    check_value("tx_analogreset", 32'(lane_reset.tx_analogreset), LANE_MASK);
    repeat ($urandom_range(12, 30)) next_cycle();
    xcvr_status.pll_locked = 1'b1;
    repeat ($urandom_range(2, 8)) next_cycle();
    check_value("tx_ready", 32'(tx_ready), 32'd0);   // tx cal still busy
    xcvr_status.tx_cal_busy = 1'b0;
    wait_ready(1'b1, 1'b0, "tx_ready after pll lock");
    check_value("rx_analogreset", 32'(lane_reset.rx_analogreset), LANE_MASK);
    repeat ($urandom_range(1, 6)) next_cycle();
    xcvr_status.rx_cal_busy = 1'b0;
    for (i = 0; i < `XCVR_LANES; i++) begin
      repeat ($urandom_range(1, 4)) next_cycle();
      xcvr_status.rx_is_lockedtodata[i] = 1'b1;
    end
    wait_ready(1'b1, 1'b1, "rx_ready after cdr settle");
    check_value("lane_reset", 32'(lane_reset), 32'd0);
  endtask

  //////////////////////////////////////////////////////////////////////
  // stimulus
  //////////////////////////////////////////////////////////////////////
  initial begin
    void'($urandom(32'ha9c0));
    mgmt_clk       = 1'b0;
    embedded_reset = 1'b1;
    mgmt_address   = '0;
    mgmt_read      = 1'b0;
    mgmt_write     = 1'b0;
    mgmt_writedata = '0;
    xcvr_status    = '0;
    xcvr_status.tx_cal_busy = 1'b1;
    xcvr_status.rx_cal_busy = 1'b1;
    repeat (8) @(posedge mgmt_clk);
    #2;
    embedded_reset = 1'b0;

    bring_up();

    // lock loss on one lane in auto mode
    lane = $urandom_range(0, `XCVR_LANES - 1);
    xcvr_status.rx_is_lockedtodata[lane] = 1'b0;
    wait_ready(1'b1, 1'b0, "rx_ready to fall on lock loss");
    check_value("rx_digitalreset", 32'(lane_reset.rx_digitalreset), LANE_MASK);
    xcvr_status.rx_is_lockedtodata[lane] = 1'b1;
    wait_ready(1'b1, 1'b1, "rx_ready after relock");

    // register map, link is fully up here
    csr_read(CSR_STATUS, rd);
    exp = '0;
    exp[0] = xcvr_status.pll_locked;
    exp[`XCVR_LANES:1] = xcvr_status.rx_is_lockedtodata;
    exp[5] = 1'b1;
    exp[6] = 1'b1;
    exp[7] = xcvr_status.tx_cal_busy;
    exp[8] = xcvr_status.rx_cal_busy;
    check_value("status", rd, exp);
    csr_read(CSR_RESET_CMD, rd);
    check_value("reset_cmd", rd, 32'd0);
    csr_read(8'h00, rd);
    check_value("undecoded 0x00", rd, 32'hffff_ffff);
    csr_read(8'h80, rd);
    check_value("undecoded 0x80", rd, 32'hffff_ffff);

    // lane overrides on top of a running link
    write_readback(CSR_TX_DIGRST, "tx_digrst", tx_val);
    write_readback(CSR_RX_ANARST, "rx_anarst", rxa_val);
    write_readback(CSR_RX_DIGRST, "rx_digrst", rxd_val);
    write_readback(CSR_LOOPBACK, "loopback", lpb_val);
    check_value("tx_digitalreset", 32'(lane_reset.tx_digitalreset), tx_val);
    check_value("rx_analogreset", 32'(lane_reset.rx_analogreset), rxa_val);
    check_value("rx_digitalreset", 32'(lane_reset.rx_digitalreset), rxd_val);
    check_value("seriallpbken", 32'(xcvr_ctrl.seriallpbken), lpb_val);
    check_value("rx_ready", 32'(rx_ready), 32'd1);
    csr_write(CSR_TX_DIGRST, 32'd0);
    csr_write(CSR_RX_ANARST, 32'd0);
    csr_write(CSR_RX_DIGRST, 32'd0);

    // reset rx command, rx cal runs again
    xcvr_status.rx_cal_busy = 1'b1;
    csr_write(CSR_RESET_CMD, 32'h2);
    wait_ready(1'b1, 1'b0, "rx_ready to fall on reset rx");
    check_value("rx_analogreset", 32'(lane_reset.rx_analogreset), LANE_MASK);
    repeat ($urandom_range(2, 6)) next_cycle();
    xcvr_status.rx_cal_busy = 1'b0;
    wait_ready(1'b1, 1'b1, "rx_ready after reset rx");

    // reset all, the transceiver model loses everything
    csr_write(CSR_RESET_CMD, 32'h1);
    wait_ready(1'b0, 1'b0, "both ready flags to fall on reset all");
    xcvr_status = '0;
    xcvr_status.tx_cal_busy = 1'b1;
    xcvr_status.rx_cal_busy = 1'b1;
    bring_up();

    // manual lock to data
    csr_write(CSR_LOCK_MODE, 32'h2);
    csr_read(CSR_LOCK_MODE, rd);
    check_value("lock_mode", rd, 32'h2);
    check_value("set_locktodata", 32'(xcvr_ctrl.set_locktodata), LANE_MASK);
    check_value("set_locktoref", 32'(xcvr_ctrl.set_locktoref), 32'd0);
    xcvr_status.rx_is_lockedtodata = '0;
    csr_write(CSR_RESET_CMD, 32'h2);
    wait_ready(1'b1, 1'b0, "rx_ready to fall in manual mode");
    wait_ready(1'b1, 1'b1, "rx_ready with lanes unlocked");
    repeat (16) begin
      xcvr_status.rx_is_lockedtodata = `XCVR_LANES'($urandom());
      next_cycle();
      check_value("rx_ready", 32'(rx_ready), 32'd1);
    end

    // manual lock to reference keeps the link up as well
    csr_write(CSR_LOCK_MODE, 32'h1);
    check_value("set_locktoref", 32'(xcvr_ctrl.set_locktoref), LANE_MASK);
    check_value("set_locktodata", 32'(xcvr_ctrl.set_locktodata), 32'd0);
    check_value("rx_ready", 32'(rx_ready), 32'd1);

    $display("Simulation completed successfully");
    $finish;
  end

endmodule

`default_nettype wire

/* list.f */
+incdir+.
xcvr_phy_pkg.sv
xcvr_reset_timer.sv
xcvr_reset_seq.sv
xcvr_mgmt_csr.sv
xcvr_phy_ctrl.sv
xcvr_phy_ctrl_sva.sv
xcvr_phy_ctrl_tb.sv

/* run.sh */
#!/bin/sh
# build and run the PHY control testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert --timescale 1ns/100ps \
  --top-module xcvr_phy_ctrl_tb -f list.f -o sim

# exit status comes from the search, so a missing pass line fails the script
./obj_dir/sim 2>&1 | tee /dev/stderr | grep -q -x "Simulation completed successfully"
echo "run.sh: testbench passed"
